//--- include/rp_defs.svh
//////////////////////////////
// Widths, channel count and reset hold count
// for the analog data path
//////////////////////////////

`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

// Converter code widths
`define RP_ADC_W     14
`define RP_DAC_W     14

// One extra bit so the sum of two samples cannot wrap
`define RP_SUM_W     15

`define RP_NCH       2   // ADC and DAC channels

// adc_clk cycles of reset after lock is seen
`define RP_RST_HOLD  64

`endif

//--- hdl/rp_sample_pkg.sv
//////////////////////////////
// Sample and converter code types
//////////////////////////////

`default_nettype none

`include "rp_defs.svh"

package rp_sample_pkg;

  //////////////////////////////
  // Converter side codes
  //////////////////////////////

  // Unsigned, negative slope
  typedef logic [`RP_ADC_W-1:0] adc_code_t;  // Raw ADC word
  typedef logic [`RP_DAC_W-1:0] dac_code_t;  // Raw DAC word

  //////////////////////////////
  // Internal arithmetic
  //////////////////////////////

  typedef logic signed [`RP_ADC_W-1:0] sample_t;  // Two's complement
  typedef logic signed [`RP_SUM_W-1:0] sum_t;     // Gen plus feedback, unsaturated

endpackage : rp_sample_pkg

`default_nettype wire

//--- hdl/rp_ctrl_pkg.sv
//////////////////////////////
// Loop mode and reset FSM enums
//////////////////////////////

`default_nettype none

package rp_ctrl_pkg;

  // DAC source select, unused codes fall back to normal output
  typedef enum logic [1:0] {
    LOOP_OFF        = 2'd0,  // Gen plus feedback
    LOOP_ADC_TO_DAC = 2'd1   // ADC straight out
  } loop_mode_e;

  // Reset release sequence
  typedef enum logic [1:0] {
    RST_WAIT_LOCK = 2'd0,  // PLL not locked
    RST_HOLD      = 2'd1,  // Counting hold cycles
    RST_RUN       = 2'd2   // Data path running
  } rst_state_e;

endpackage : rp_ctrl_pkg

`default_nettype wire

//--- hdl/rp_chan_if.sv
//////////////////////////////
// Per channel sample interface
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface rp_chan_if
  import rp_sample_pkg::*;
();

  // Front end to channel
  sample_t adc_smp;  // Converted ADC sample
  sample_t gen_smp;  // Generator sample
  sample_t fb_smp;   // Feedback sample
  logic    smp_stb;  // One cycle, data valid

  // Channel to output stage
  sample_t out_smp;  // Saturated sum
  sample_t byp_smp;  // ADC sample, aligned with out_smp
  logic    out_stb;

  modport front (
    output adc_smp, gen_smp, fb_smp, smp_stb
  );

  modport chan (
    input  adc_smp, gen_smp, fb_smp, smp_stb,
    output out_smp, byp_smp, out_stb
  );

  modport out (
    input  out_smp, byp_smp, out_stb
  );

endinterface : rp_chan_if

`default_nettype wire

//--- hdl/rp_reset_gen.sv
//////////////////////////////
// PLL lock synchronizer and reset hold FSM
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module rp_reset_gen
  import rp_ctrl_pkg::*;
(
  input  logic adc_clk,
  input  logic rst_n_i,
  input  logic pll_locked_i,  // Async to adc_clk
  output logic run_o          // Data path enable
);

  localparam int CNT_W = $clog2(`RP_RST_HOLD);

  logic             lock_ff1;   // First sync stage
  logic             lock_sync;  // Second stage, fully settled
  rst_state_e       state;
  logic [CNT_W-1:0] hold_cnt;

  //////////////////////////////
  // Lock synchronizer
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_ff1  <= 1'b0;
      lock_sync <= 1'b0;
    end else begin
      lock_ff1  <= pll_locked_i;
      lock_sync <= lock_ff1;
    end
  end

  //////////////////////////////
  // Hold FSM
  //////////////////////////////

  // State register acts as the second stage behind lock_ff1
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state    <= RST_WAIT_LOCK;
      hold_cnt <= '0;
    end else if (!lock_ff1) begin
      state    <= RST_WAIT_LOCK;  // Lock lost, start over
      hold_cnt <= '0;
    end else begin
      case (state)
        RST_WAIT_LOCK: state <= RST_HOLD;
        RST_HOLD: begin
          hold_cnt <= hold_cnt + 1'b1;
          if (hold_cnt == CNT_W'(`RP_RST_HOLD - 1))
            state <= RST_RUN;
        end
        RST_RUN: state <= RST_RUN;
        default: state <= RST_WAIT_LOCK;
      endcase
    end
  end

  assign run_o = (state == RST_RUN);

  // Run must trail the settled lock, never lead it
  a_run_locked: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !lock_sync |-> !run_o);

endmodule : rp_reset_gen

`default_nettype wire

//--- hdl/rp_adc_front.sv
//////////////////////////////
// ADC code conversion and sample strobe
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module rp_adc_front
  import rp_sample_pkg::*;
(
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  logic      run_i,    // From reset generator
  input  adc_code_t adc_a_i,
  input  adc_code_t adc_b_i,
  input  logic      adc_dv_i,
  input  sample_t   gen_a_i,
  input  sample_t   gen_b_i,
  input  sample_t   fb_a_i,
  input  sample_t   fb_b_i,
  rp_chan_if.front  ch_o [`RP_NCH]
);

  localparam int MSB = `RP_ADC_W - 1;

  adc_code_t adc_code [`RP_NCH];
  sample_t   gen_in   [`RP_NCH];
  sample_t   fb_in    [`RP_NCH];
  logic      smp_acc;

  // Channel order A, B
  assign adc_code[0] = adc_a_i;
  assign adc_code[1] = adc_b_i;
  assign gen_in[0]   = gen_a_i;
  assign gen_in[1]   = gen_b_i;
  assign fb_in[0]    = fb_a_i;
  assign fb_in[1]    = fb_b_i;

  assign smp_acc = adc_dv_i & run_i;  // Drop samples until running

  //////////////////////////////
  // Per channel registers
  //////////////////////////////

  for (genvar g = 0; g < `RP_NCH; g++) begin : g_ch
    // Neg slope to two's complement, sign kept
    always_ff @(posedge adc_clk) begin
      if (smp_acc) begin
        ch_o[g].adc_smp <= {adc_code[g][MSB], ~adc_code[g][MSB-1:0]};
        ch_o[g].gen_smp <= gen_in[g];
        ch_o[g].fb_smp  <= fb_in[g];
      end
    end

    always_ff @(posedge adc_clk or negedge rst_n_i) begin
      if (!rst_n_i)
        ch_o[g].smp_stb <= 1'b0;
      else
        ch_o[g].smp_stb <= smp_acc;  // Same cycle as the data
    end
  end

endmodule : rp_adc_front

`default_nettype wire

//--- hdl/rp_dac_chan.sv
//////////////////////////////
// Sum, saturation and register stage
// for one DAC channel
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module rp_dac_chan
  import rp_sample_pkg::*;
(
  input  logic     adc_clk,
  input  logic     rst_n_i,
  rp_chan_if.chan  ch
);

  localparam int SMSB = `RP_SUM_W - 1;

  // Sample rails
  localparam sample_t SMP_MAX = {1'b0, {(`RP_ADC_W-1){1'b1}}};
  localparam sample_t SMP_MIN = {1'b1, {(`RP_ADC_W-1){1'b0}}};

  sum_t    sum;
  sample_t sat;

  //////////////////////////////
  // Sum and saturate
  //////////////////////////////

  // Sign extend both before adding
  assign sum = sum_t'(ch.gen_smp) + sum_t'(ch.fb_smp);

  always_comb begin
    if (sum[SMSB] ^ sum[SMSB-1])            // Top two bits differ, out of range
      sat = sum[SMSB] ? SMP_MIN : SMP_MAX;  // Clip toward the sign
    else
      sat = sum[`RP_ADC_W-1:0];
  end

  //////////////////////////////
  // Output registers
  //////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (ch.smp_stb) begin
      ch.out_smp <= sat;
      ch.byp_smp <= ch.adc_smp;  // Keeps loopback in step
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i)
      ch.out_stb <= 1'b0;
    else
      ch.out_stb <= ch.smp_stb;
  end

  // Integer clip against the sample rails
  function automatic int clip_int(int s);
    return (s > int'(SMP_MAX)) ? int'(SMP_MAX) : ((s < int'(SMP_MIN)) ? int'(SMP_MIN) : s);
  endfunction

  // Registered result equals the clipped sum of the strobed inputs
  a_sat_range: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    ch.smp_stb |=>
      int'(ch.out_smp) == clip_int(int'($past(ch.gen_smp)) + int'($past(ch.fb_smp))));

endmodule : rp_dac_chan

`default_nettype wire

//--- hdl/rp_dac_out.sv
//////////////////////////////
// Loop select, DAC code conversion
// and output registers
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module rp_dac_out
  import rp_sample_pkg::*;
  import rp_ctrl_pkg::*;
(
  input  logic       adc_clk,
  input  logic       rst_n_i,
  input  loop_mode_e loop_mode_i,
  rp_chan_if.out     ch_i [`RP_NCH],
  output dac_code_t  dac_a_o,
  output dac_code_t  dac_b_o,
  output logic       dac_dv_o
);

  localparam int        MSB      = `RP_DAC_W - 1;
  localparam dac_code_t DAC_ZERO = 14'h2000;  // Idle DAC level

  sample_t   sel_smp  [`RP_NCH];
  dac_code_t dac_code [`RP_NCH];
  logic      ch_stb   [`RP_NCH];

  //////////////////////////////
  // Source select and flip
  //////////////////////////////

  for (genvar g = 0; g < `RP_NCH; g++) begin : g_sel
    // Unknown modes act as LOOP_OFF
    assign sel_smp[g]  = (loop_mode_i == LOOP_ADC_TO_DAC) ? ch_i[g].byp_smp
                                                          : ch_i[g].out_smp;
    // Back to unsigned neg slope
    assign dac_code[g] = {sel_smp[g][MSB], ~sel_smp[g][MSB-1:0]};
    assign ch_stb[g]   = ch_i[g].out_stb;
  end

  //////////////////////////////
  // Output registers
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_a_o  <= DAC_ZERO;
      dac_b_o  <= DAC_ZERO;
      dac_dv_o <= 1'b0;
    end else begin
      dac_dv_o <= ch_stb[0];  // Channels run in lockstep
      if (ch_stb[0]) begin
        dac_a_o <= dac_code[0];
        dac_b_o <= dac_code[1];
      end                     // Otherwise hold last code
    end
  end

  // Both channel pipelines must strobe together
  a_stb_match: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    ch_stb[0] == ch_stb[1]);

endmodule : rp_dac_out

`default_nettype wire

//--- hdl/rp_top.sv
//////////////////////////////
// Analog data path top level
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module rp_top
  import rp_sample_pkg::*;
  import rp_ctrl_pkg::*;
(
  input  logic       adc_clk,
  input  logic       rst_n_i,
  input  logic       pll_locked_i,
  // ADC
  input  adc_code_t  adc_a_i,       // CH 1, neg slope
  input  adc_code_t  adc_b_i,       // CH 2, neg slope
  input  logic       adc_dv_i,
  // Generator and feedback samples
  input  sample_t    gen_a_i,
  input  sample_t    gen_b_i,
  input  sample_t    fb_a_i,
  input  sample_t    fb_b_i,
  input  loop_mode_e loop_mode_i,
  // DAC
  output dac_code_t  dac_a_o,
  output dac_code_t  dac_b_o,
  output logic       dac_dv_o
);

  logic run;  // High once reset hold is done

  rp_chan_if ch [`RP_NCH] ();  // One per channel

  //////////////////////////////
  // Reset release
  //////////////////////////////

  rp_reset_gen i_reset_gen (
    .adc_clk      (adc_clk     ),
    .rst_n_i      (rst_n_i     ),
    .pll_locked_i (pll_locked_i),
    .run_o        (run         )
  );

  //////////////////////////////
  // Data path
  //////////////////////////////

  rp_adc_front i_adc_front (
    .adc_clk  (adc_clk ),
    .rst_n_i  (rst_n_i ),
    .run_i    (run     ),
    .adc_a_i  (adc_a_i ),
    .adc_b_i  (adc_b_i ),
    .adc_dv_i (adc_dv_i),
    .gen_a_i  (gen_a_i ),
    .gen_b_i  (gen_b_i ),
    .fb_a_i   (fb_a_i  ),
    .fb_b_i   (fb_b_i  ),
    .ch_o     (ch      )
  );

  for (genvar g = 0; g < `RP_NCH; g++) begin : g_chan
    rp_dac_chan i_dac_chan (
      .adc_clk (adc_clk),
      .rst_n_i (rst_n_i),
      .ch      (ch[g]  )
    );
  end

  rp_dac_out i_dac_out (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (rst_n_i    ),
    .loop_mode_i (loop_mode_i),
    .ch_i        (ch         ),
    .dac_a_o     (dac_a_o    ),
    .dac_b_o     (dac_b_o    ),
    .dac_dv_o    (dac_dv_o   )
  );

endmodule : rp_top

`default_nettype wire

//--- tb/tb_rp_top.sv
//////////////////////////////
// Testbench for rp_top: stimulus, queue model, checks
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module tb_rp_top
  import rp_sample_pkg::*;
  import rp_ctrl_pkg::*;
;

  localparam int CLK_HALF    = 20;                            // 40 ns period
  localparam int WATCHDOG_NS = (16 + 100 + 4 * 300) * 40;
  localparam int SMP_MAX     = (1 << (`RP_ADC_W - 1)) - 1;    // 8191
  localparam int SMP_MIN     = -(1 << (`RP_ADC_W - 1));       // -8192

  typedef struct packed {
    dac_code_t   nrm_a;  // Gen plus fb path
    dac_code_t   nrm_b;
    dac_code_t   byp_a;  // Loopback path
    dac_code_t   byp_b;
    logic [31:0] due;    // Model cycle of output
  } exp_entry_t;

  logic       adc_clk, rst_n_i, pll_locked_i, adc_dv_i;
  adc_code_t  adc_a_i, adc_b_i;
  sample_t    gen_a_i, gen_b_i, fb_a_i, fb_b_i;
  loop_mode_e loop_mode_i;
  dac_code_t  dac_a_o, dac_b_o;
  logic       dac_dv_o;

  int         seed = 32'hf611_06d8;
  int         err_dv, err_a, err_b, err_other;
  int         sat_hi, sat_lo, loop_hits;   // Reach counters
  exp_entry_t pend [$];                    // Samples in flight
  logic       exp_dv;
  dac_code_t  exp_a, exp_b;
  logic       run_m, ff1_m;                // Reset release model
  int         hold_m, cyc;

  rp_top dut0 (
    .adc_clk(adc_clk), .rst_n_i(rst_n_i), .pll_locked_i(pll_locked_i),
    .adc_a_i(adc_a_i), .adc_b_i(adc_b_i), .adc_dv_i(adc_dv_i),
    .gen_a_i(gen_a_i), .gen_b_i(gen_b_i), .fb_a_i(fb_a_i), .fb_b_i(fb_b_i),
    .loop_mode_i(loop_mode_i),
    .dac_a_o(dac_a_o), .dac_b_o(dac_b_o), .dac_dv_o(dac_dv_o)
  );

  always #CLK_HALF adc_clk = ~adc_clk;

  //////////////////////////////
  // Reference rules
  //////////////////////////////

  function automatic int from_adc(adc_code_t c);
    return SMP_MAX - int'(c);    // Neg slope code to signed value
  endfunction

  function automatic dac_code_t to_dac(int s);
    return dac_code_t'(SMP_MAX - s);  // Signed value to neg slope code
  endfunction

  function automatic int clip(int s);
    return (s > SMP_MAX) ? SMP_MAX : ((s < SMP_MIN) ? SMP_MIN : s);
  endfunction

  // Queue model, outputs mirror the DUT registers
  always @(posedge adc_clk or negedge rst_n_i) begin : model
    exp_entry_t ent;
    int         s_a, s_b;
    if (!rst_n_i) begin
      cyc = 0;
      ff1_m = 1'b0;
      hold_m = 0;
      run_m = 1'b0;
      pend.delete();
      exp_dv <= 1'b0;
      exp_a  <= 14'h2000;   // DAC zero
      exp_b  <= 14'h2000;
    end else begin
      cyc = cyc + 1;
      if (adc_dv_i && run_m) begin           // Accept on run before this edge
        s_a = int'(gen_a_i) + int'(fb_a_i);
        s_b = int'(gen_b_i) + int'(fb_b_i);
        if (s_a > SMP_MAX || s_b > SMP_MAX) sat_hi++;
        if (s_a < SMP_MIN || s_b < SMP_MIN) sat_lo++;
        ent.nrm_a = to_dac(clip(s_a));
        ent.nrm_b = to_dac(clip(s_b));
        ent.byp_a = to_dac(from_adc(adc_a_i));
        ent.byp_b = to_dac(from_adc(adc_b_i));
        ent.due   = 32'(cyc + 2);
        pend.push_back(ent);
      end
      hold_m = ff1_m ? hold_m + 1 : 0;       // Count behind first sync stage
      ff1_m  = pll_locked_i;
      run_m  = (hold_m > `RP_RST_HOLD);
      if (pend.size() != 0 && pend[0].due == 32'(cyc)) begin
        ent = pend.pop_front();
        exp_dv <= 1'b1;
        if (loop_mode_i == LOOP_ADC_TO_DAC) begin
          loop_hits++;
          exp_a <= ent.byp_a;
          exp_b <= ent.byp_b;
        end else begin
          exp_a <= ent.nrm_a;
          exp_b <= ent.nrm_b;
        end
      end else begin
        exp_dv <= 1'b0;   // Codes hold
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_dv: assert property (@(posedge adc_clk) disable iff (!rst_n_i) dac_dv_o == exp_dv)
    else begin
      err_dv++;
      $display("error at %0t: dac_dv_o is %b, expected %b", $time,
               $sampled(dac_dv_o), $sampled(exp_dv));
    end

  a_code_a: assert property (@(posedge adc_clk) disable iff (!rst_n_i) dac_a_o == exp_a)
    else begin
      err_a++;
      $display("error at %0t: dac_a_o is %h, expected %h", $time,
               $sampled(dac_a_o), $sampled(exp_a));
    end

  a_code_b: assert property (@(posedge adc_clk) disable iff (!rst_n_i) dac_b_o == exp_b)
    else begin
      err_b++;
      $display("error at %0t: dac_b_o is %h, expected %h", $time,
               $sampled(dac_b_o), $sampled(exp_b));
    end

  // Accepted strobe shows up three edges later
  a_latency: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (adc_dv_i && run_m) |-> ##3 dac_dv_o)
    else begin
      err_other++;
      $display("accepted sample at %0t did not reach dac_dv_o after 3 cycles", $time);
    end

  // Output goes quiet once lock loss has passed the sync
  a_lock_loss: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $fell(pll_locked_i) |-> ##5 !dac_dv_o)
    else begin
      err_other++;
      $display("dac_dv_o still active at %0t after PLL lock was lost", $time);
    end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic drive_samples(input int n, input bit dv_all, input bit wide);
    int r;
    repeat (n) begin
      @(posedge adc_clk);
      adc_dv_i <= dv_all ? 1'b1 : (($random(seed) & 3) != 0);  // 3 in 4 otherwise
      adc_a_i  <= adc_code_t'($random(seed));
      adc_b_i  <= adc_code_t'($random(seed));
      r = $random(seed);
      gen_a_i  <= wide ? r[13:0] : {r[13], r[13:1]};   // Half range keeps sums in range
      r = $random(seed);
      gen_b_i  <= wide ? r[13:0] : {r[13], r[13:1]};
      r = $random(seed);
      fb_a_i   <= wide ? r[13:0] : {r[13], r[13:1]};
      r = $random(seed);
      fb_b_i   <= wide ? r[13:0] : {r[13], r[13:1]};
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired, simulation did not finish in time");
    $display("test failed");
    $finish;
  end

  initial begin : main
    adc_clk      = 1'b0;
    rst_n_i      = 1'b0;
    pll_locked_i = 1'b0;
    adc_dv_i     = 1'b0;
    adc_a_i      = '0;
    adc_b_i      = '0;
    gen_a_i      = '0;
    gen_b_i      = '0;
    fb_a_i       = '0;
    fb_b_i       = '0;
    loop_mode_i  = LOOP_OFF;
    repeat (16) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    repeat (10) @(posedge adc_clk);
    pll_locked_i <= 1'b1;
    drive_samples(80, 1'b1, 1'b0);    // Strobes during hold
    @(posedge adc_clk);
    pll_locked_i <= 1'b0;             // Lock drop
    drive_samples(4, 1'b1, 1'b0);
    @(posedge adc_clk);
    pll_locked_i <= 1'b1;
    drive_samples(80, 1'b1, 1'b0);    // Second release
    drive_samples(300, 1'b0, 1'b0);   // In range sums
    drive_samples(300, 1'b0, 1'b1);   // Saturation
    @(posedge adc_clk);
    loop_mode_i <= LOOP_ADC_TO_DAC;
    drive_samples(300, 1'b0, 1'b1);   // Loopback
    @(posedge adc_clk);
    adc_dv_i <= 1'b0;
    repeat (8) @(posedge adc_clk);    // Drain pipeline
    if (sat_hi == 0 || sat_lo == 0) begin
      err_other++;
      $display("saturation limits were never reached by the stimulus");
    end
    if (loop_hits == 0) begin
      err_other++;
      $display("no sample went through the loopback path");
    end
    if (pend.size() != 0) begin
      err_other++;
      $display("%0d expected samples never appeared at the DAC", pend.size());
    end
    $display("errors: dac_dv_o %0d, dac_a_o %0d, dac_b_o %0d, other %0d",
             err_dv, err_a, err_b, err_other);
    if (err_dv + err_a + err_b + err_other == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : tb_rp_top

`default_nettype wire

//--- list.f
+incdir+include
hdl/rp_sample_pkg.sv
hdl/rp_ctrl_pkg.sv
hdl/rp_chan_if.sv
hdl/rp_reset_gen.sv
hdl/rp_adc_front.sv
hdl/rp_dac_chan.sv
hdl/rp_dac_out.sv
hdl/rp_top.sv
tb/tb_rp_top.sv

//--- run.sh
#!/bin/sh
# Build and run the rp_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_rp_top -Mdir obj_dir -o sim_rp_top; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_rp_top > "$LOG" 2>&1
rc=$?
cat "$LOG"

if [ $rc -ne 0 ]; then
  echo "Simulation exited with status $rc"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi
